// File: files.f
i650_pkg.sv
timing_if.sv
timing_ring.sv
validity_check.sv
restart_reset.sv
error_stop.sv
run_control.sv
error_console.sv
error_console_checker.sv
tb_error_console.sv

// File: Bender.yml
package:
  name: error_console

sources:
  # rtl in compile order
  - i650_pkg.sv
  - timing_if.sv
  - timing_ring.sv
  - validity_check.sv
  - restart_reset.sv
  - error_stop.sv
  - run_control.sv
  - error_console.sv
  # testbench and bound assertions
  - target: test
    files:
      - error_console_checker.sv
      - tb_error_console.sv

// File: tb_error_console.sv
`timescale 1ns/10ps
`default_nettype none

module tb_error_console;

   import i650_pkg::*;

   localparam int HALF_PERIOD = 2;
   localparam int WORD_CYCLES = DIGITS_PER_WORD * DP_DIV;
   localparam int BAND_CYCLES = WORDS_PER_BAND * WORD_CYCLES;
   localparam int NUM_TESTS   = 6;
   // two band times per entry, plus ten words of slack
   localparam int WATCHDOG_NS = (NUM_TESTS * 2 * BAND_CYCLES + 10 * WORD_CYCLES) * 2 * HALF_PERIOD;

   // error kinds of a table entry
   localparam logic [1:0] K_NONE  = 2'd0;
   localparam logic [1:0] K_BAD   = 2'd1;
   localparam logic [1:0] K_CLOCK = 2'd2;
   localparam logic [1:0] K_BOTH  = 2'd3;

   // port selectors for polling waits
   localparam int P_ERR_STOP = 0;
   localparam int P_RUN      = 1;
   localparam int P_BUSY     = 2;

   typedef struct packed {
      logic [1:0] kind;
      logic       restart_sw;
      logic       second;
      err_cause_e exp_cause;
   } entry_t;

   logic                ap;
   logic                rst;
   logic [BQ_WIDTH-1:0] digit;
   logic                check_en;
   logic                clock_err;
   logic                err_restart_sw;
   logic                err_reset;
   logic                err_sense_reset;
   logic                start_key;
   logic                err_stop;
   logic                err_sense_light;
   logic                run;
   logic                restart_reset_busy;
   err_cause_e          cause;

   entry_t      tests [NUM_TESTS];
   logic [31:0] lcg;
   logic        bad_now;
   int          errors;
   int          checks;
   int          failed;
   int          err_before;
   int          cyc;

   error_console UUT (
      .ap                 (ap),
      .rst                (rst),
      .digit              (digit),
      .check_en           (check_en),
      .clock_err          (clock_err),
      .err_restart_sw     (err_restart_sw),
      .err_reset          (err_reset),
      .err_sense_reset    (err_sense_reset),
      .start_key          (start_key),
      .err_stop           (err_stop),
      .err_sense_light    (err_sense_light),
      .run                (run),
      .cause              (cause),
      .restart_reset_busy (restart_reset_busy)
   );

   initial begin
      ap = 1'b0;
      forever #HALF_PERIOD ap = ~ap;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t, the tests did not finish in time", $time);
      $display("RESULT: FAIL");
      $finish;
   end

   // ap cycles since reset release
   // dp is sampled on the edge that makes this a multiple of DP_DIV
   always @(posedge ap) begin
      if (rst) begin
         cyc <= 0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   // --------------------
   // stimulus helpers
   // --------------------

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // one bi bit and one quinary bit set
   function automatic logic [BQ_WIDTH-1:0] valid_digit(input logic [31:0] r);
      logic [1:0] bi;
      logic [4:0] qui;
      bi  = r[16] ? 2'b10 : 2'b01;
      qui = 5'b00001 << (r[31:24] % 8'd5);
      return {bi, qui};
   endfunction

   // both bi bits set, or no quinary bit
   function automatic logic [BQ_WIDTH-1:0] bad_digit(input logic [31:0] r);
      logic [BQ_WIDTH-1:0] d;
      d = valid_digit(r);
      return r[20] ? {2'b11, d[4:0]} : {d[6:5], 5'b00000};
   endfunction

   // advance to the next falling edge and drive a fresh digit
   task automatic step_cycle();
      @(negedge ap);
      lcg   = lcg_next(lcg);
      digit = bad_now ? bad_digit(lcg) : valid_digit(lcg);
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
         errors++;
      end
   endtask

   function automatic logic port_value(input int sel);
      case (sel)
         P_ERR_STOP: return err_stop;
         P_RUN:      return run;
         default:    return restart_reset_busy;
      endcase
   endfunction

   task automatic wait_port(input int sel, input logic val, input int limit, input string what);
      int n;
      n = 0;
      while (port_value(sel) !== val && n < limit) begin
         step_cycle();
         n++;
      end
      if (port_value(sel) !== val) begin
         $display("timeout at %0t: no %s within %0d cycles", $time, what, limit);
         errors++;
      end
   endtask

   // bad code held one digit period, so a single dp captures it
   task automatic inject_error(input logic [1:0] kind);
      int clk_start;
      int clk_end;
      int total;
      int i;
      // the first loop step then drives the bad digit just ahead of a dp edge
      if (kind == K_BOTH) begin
         while (cyc % DP_DIV != DP_DIV - 2) begin
            step_cycle();
         end
      end
      // clock error first seen on the edge where the validity pulse lands
      clk_start = (kind == K_BOTH) ? 2 : 0;
      clk_end   = (kind == K_CLOCK) ? 1 : (kind == K_BOTH) ? DP_DIV + 2 : 0;
      total     = (clk_end > DP_DIV) ? clk_end : DP_DIV;
      bad_now   = (kind == K_BAD) || (kind == K_BOTH);
      for (i = 0; i <= total; i++) begin
         if (i == DP_DIV) begin
            bad_now = 1'b0;
         end
         step_cycle();
         if (i == clk_start && clk_end > 0) begin
            clock_err = 1'b1;
         end
         if (i == clk_end) begin
            clock_err = 1'b0;
         end
      end
   endtask

   // seen on exactly one dp
   task automatic press_err_reset();
      err_reset = 1'b1;
      repeat (DP_DIV) step_cycle();
      err_reset = 1'b0;
      step_cycle();
   endtask

   // --------------------
   // one table entry
   // --------------------

   task automatic run_entry(input entry_t e);
      int   n;
      logic seen;
      err_restart_sw = e.restart_sw;
      start_key      = 1'b1;
      step_cycle();
      start_key = 1'b0;
      wait_port(P_RUN, 1'b1, DP_DIV, "run after start key");
      if (e.kind == K_NONE) begin
         seen = 1'b0;
         for (n = 0; n < BAND_CYCLES; n++) begin
            step_cycle();
            seen = seen | err_stop | !run;
         end
         check(seen, 1'b0, "stop or run drop over a band of valid digits");
         check(cause, cause_none, "cause with valid digits");
      end else begin
         inject_error(e.kind);
         wait_port(P_ERR_STOP, 1'b1, 4 * DP_DIV, "err_stop after error");
         if (!e.restart_sw) begin
            wait_port(P_RUN, 1'b0, WORD_CYCLES + DP_DIV, "run drop within a word");
            check(cause, e.exp_cause, "cause after error stop");
            seen = 1'b0;
            for (n = 0; n < WORD_CYCLES; n++) begin
               step_cycle();
               seen = seen | run;
            end
            check(seen, 1'b0, "run held low while stopped");
            check(err_stop, 1'b1, "err_stop held until err_reset");
            check(err_sense_light, 1'b0, "light with restart switch off");
         end else begin
            step_cycle();
            step_cycle();
            check(err_sense_light, 1'b1, "light on error with restart switch on");
            wait_port(P_BUSY, 1'b1, 3 * WORD_CYCLES, "restart_reset_busy");
            check(run, 1'b0, "run during restart reset");
            n = 0;
            while (restart_reset_busy && n < 2 * WORD_CYCLES) begin
               n++;
               step_cycle();
            end
            check(n, WORD_CYCLES, "restart_reset_busy length in ap cycles");
            check(err_stop, 1'b1, "err_stop through restart reset");
            if (e.second) begin
               inject_error((e.kind == K_BAD) ? K_CLOCK : K_BAD);
            end
            wait_port(P_RUN, 1'b1, 2 * BAND_CYCLES, "run after restart");
            check(err_stop, 1'b0, "err_stop after restart");
            check(cause, e.exp_cause, "cause kept through restart");
            check(err_sense_light, 1'b1, "light held after restart");
            err_sense_reset = 1'b1;
            step_cycle();
            err_sense_reset = 1'b0;
            step_cycle();
            check(err_sense_light, 1'b0, "light after err_sense_reset");
         end
         press_err_reset();
         check(err_stop, 1'b0, "err_stop after err_reset");
         check(cause, cause_none, "cause after err_reset");
      end
   endtask

   // --------------------
   // main sequence
   // --------------------

   initial begin
      lcg             = 32'he8104f9f;
      bad_now         = 1'b0;
      rst             = 1'b1;
      digit           = valid_digit(lcg);
      check_en        = 1'b1;
      clock_err       = 1'b0;
      err_restart_sw  = 1'b0;
      err_reset       = 1'b0;
      err_sense_reset = 1'b0;
      start_key       = 1'b0;
      errors          = 0;
      checks          = 0;
      failed          = 0;
      // kind, restart switch, second error, expected cause
      tests[0] = '{K_NONE,  1'b0, 1'b0, cause_none};
      tests[1] = '{K_BAD,   1'b0, 1'b0, cause_validity};
      tests[2] = '{K_CLOCK, 1'b0, 1'b0, cause_clock};
      tests[3] = '{K_BOTH,  1'b0, 1'b0, cause_clock};
      tests[4] = '{K_BAD,   1'b1, 1'b1, cause_validity};
      tests[5] = '{K_CLOCK, 1'b1, 1'b0, cause_clock};
      repeat (3) step_cycle();
      rst = 1'b0;
      // outputs straight out of reset
      check(err_stop, 1'b0, "err_stop after reset");
      check(run, 1'b0, "run after reset");
      check(err_sense_light, 1'b0, "light after reset");
      check(restart_reset_busy, 1'b0, "busy after reset");
      check(cause, cause_none, "cause after reset");
      for (int i = 0; i < NUM_TESTS; i++) begin
         err_before = errors;
         run_entry(tests[i]);
         if (errors == err_before) begin
            $display("test %0d passed, kind %0d, restart switch %0b",
                     i, tests[i].kind, tests[i].restart_sw);
         end else begin
            failed++;
            $display("test %0d failed with %0d errors", i, errors - err_before);
         end
      end
      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               NUM_TESTS, failed, checks, errors, UUT.u_stop.u_checker.fail_count);
      if (errors == 0 && UUT.u_stop.u_checker.fail_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: error_console_checker.sv
`timescale 1ns/10ps
`default_nettype none

// properties on the stop / restart pulses of error_stop
module error_console_checker (
   input wire logic ap,
   input wire logic rst,
   input wire logic err_stop,
   input wire logic err_stop_ed0u,
   input wire logic err_sense_restart,
   input wire logic restart_reset,
   input wire logic restart_reset_busy
);

   // failed property count
   int fail_count = 0;

   // --------------------
   // pulse shapes
   // --------------------

   // run-latch clear is a single cycle
   ed0u_single: assert property (@(posedge ap) disable iff (rst)
      err_stop_ed0u |=> !err_stop_ed0u)
      else begin
         $error("err_stop_ed0u lasted more than one cycle");
         fail_count++;
      end

   // request drops only once busy has been seen
   reset_drop_after_busy: assert property (@(posedge ap) disable iff (rst)
      $fell(restart_reset) |-> $past(restart_reset_busy))
      else begin
         $error("restart_reset fell before restart_reset_busy was seen");
         fail_count++;
      end

   // resume and stop release share one edge
   restart_clears_stop: assert property (@(posedge ap) disable iff (rst)
      err_sense_restart |-> $fell(err_stop))
      else begin
         $error("err_sense_restart without err_stop falling");
         fail_count++;
      end

endmodule

bind error_stop error_console_checker u_checker (
   .ap                 (ap),
   .rst                (rst),
   .err_stop           (err_stop),
   .err_stop_ed0u      (err_stop_ed0u),
   .err_sense_restart  (err_sense_restart),
   .restart_reset      (restart_reset),
   .restart_reset_busy (restart_reset_busy)
);

`default_nettype wire

// File: error_console.sv
`timescale 1ns/10ps
`default_nettype none

module error_console (
   input  wire logic                          ap,
   input  wire logic                          rst,
   input  wire logic [i650_pkg::BQ_WIDTH-1:0] digit,
   input  wire logic                          check_en,
   input  wire logic                          clock_err,
   input  wire logic                          err_restart_sw,
   input  wire logic                          err_reset,
   input  wire logic                          err_sense_reset,
   input  wire logic                          start_key,
   output logic                               err_stop,
   output logic                               err_sense_light,
   output logic                               run,
   output i650_pkg::err_cause_e               cause,
   output logic                               restart_reset_busy
);

   // digit strobes shared by all blocks
   timing_if tim ();

   logic err_stop_sig;
   logic restart_reset;
   logic err_stop_ed0u;
   logic err_sense_restart;

   timing_ring u_ring (
      .ap  (ap),
      .rst (rst),
      .tim (tim.src)
   );

   // bad digit check on the distributor stream
   validity_check u_check (
      .ap           (ap),
      .rst          (rst),
      .tim          (tim.usr),
      .digit        (digit),
      .check_en     (check_en),
      .err_stop_sig (err_stop_sig)
   );

   restart_reset u_restart (
      .ap                 (ap),
      .rst                (rst),
      .tim                (tim.usr),
      .restart_reset      (restart_reset),
      .restart_reset_busy (restart_reset_busy)
   );

   error_stop u_stop (
      .ap                 (ap),
      .rst                (rst),
      .tim                (tim.usr),
      .err_restart_sw     (err_restart_sw),
      .err_reset          (err_reset),
      .err_sense_reset    (err_sense_reset),
      .clock_err_sig      (clock_err),
      .err_stop_sig       (err_stop_sig),
      .restart_reset_busy (restart_reset_busy),
      .err_sense_light    (err_sense_light),
      .err_stop           (err_stop),
      .err_stop_ed0u      (err_stop_ed0u),
      .err_sense_restart  (err_sense_restart),
      .restart_reset      (restart_reset)
   );

   // run latch and cause follow the stop fsm
   run_control u_run (
      .ap                (ap),
      .rst               (rst),
      .start_key         (start_key),
      .err_stop_ed0u     (err_stop_ed0u),
      .err_sense_restart (err_sense_restart),
      .clock_err_sig     (clock_err),
      .err_stop_sig      (err_stop_sig),
      .err_reset         (err_reset),
      .err_stop          (err_stop),
      .run               (run),
      .cause             (cause)
   );

endmodule

`default_nettype wire

// File: run_control.sv
`timescale 1ns/10ps
`default_nettype none

module run_control (
   input  wire logic           ap,
   input  wire logic           rst,
   input  wire logic           start_key,
   input  wire logic           err_stop_ed0u,
   input  wire logic           err_sense_restart,
   input  wire logic           clock_err_sig,
   input  wire logic           err_stop_sig,
   input  wire logic           err_reset,
   input  wire logic           err_stop,
   output logic                run,
   output i650_pkg::err_cause_e cause
);

   import i650_pkg::*;

   // --------------------
   // run latch
   // --------------------

   always_ff @(posedge ap) begin
      if (rst) begin
         run <= 1'b0;
      end else if (err_stop_ed0u) begin
         // stop takes priority
         run <= 1'b0;
      end else if (start_key || err_sense_restart) begin
         run <= 1'b1;
      end
   end

   // --------------------
   // stop cause
   // --------------------

   always_ff @(posedge ap) begin
      if (rst) begin
         cause <= cause_none;
      end else if (err_reset) begin
         cause <= cause_none;
      end else if (!err_stop && cause == cause_none) begin
         // first error only, clock before validity
         if (clock_err_sig) begin
            cause <= cause_clock;
         end else if (err_stop_sig) begin
            cause <= cause_validity;
         end
      end
   end

endmodule

`default_nettype wire

// File: error_stop.sv
`timescale 1ns/10ps
`default_nettype none

module error_stop (
   input  wire logic ap,
   input  wire logic rst,
   timing_if.usr     tim,
   input  wire logic err_restart_sw,
   input  wire logic err_reset,
   input  wire logic err_sense_reset,
   input  wire logic clock_err_sig,
   input  wire logic err_stop_sig,
   input  wire logic restart_reset_busy,
   output logic      err_sense_light,
   output logic      err_stop,
   output logic      err_stop_ed0u,
   output logic      err_sense_restart,
   output logic      restart_reset
);

   import i650_pkg::*;

   restart_state_e state;
   logic           err_pend;
   logic           err_any;

   // --------------------
   // error-sense latch
   // --------------------

   // only drives the console light
   always_ff @(posedge ap) begin
      if (rst) begin
         err_sense_light <= 1'b0;
      end else if (err_sense_reset) begin
         err_sense_light <= 1'b0;
      end else if (err_stop && err_restart_sw) begin
         err_sense_light <= 1'b1;
      end
   end

   // --------------------
   // pending error
   // --------------------

   // pulses come between strobes, the fsm only looks on dp
   assign err_any = err_pend || clock_err_sig || err_stop_sig;

   always_ff @(posedge ap) begin
      if (rst) begin
         err_pend <= 1'b0;
      end else if (tim.dp && state == idle) begin
         // consumed, or dropped if err_stop is already up
         err_pend <= 1'b0;
      end else if (!err_stop && (clock_err_sig || err_stop_sig)) begin
         err_pend <= 1'b1;
      end
   end

   // --------------------
   // stop / restart fsm
   // --------------------

   always_ff @(posedge ap) begin
      if (rst) begin
         state             <= idle;
         err_stop          <= 1'b0;
         err_stop_ed0u     <= 1'b0;
         err_sense_restart <= 1'b0;
         restart_reset     <= 1'b0;
      end else begin
         // one-cycle pulses
         err_stop_ed0u     <= 1'b0;
         err_sense_restart <= 1'b0;
         if (tim.dp) begin
            case (state)
               idle: begin
                  // reset key wins over a new error
                  if (err_reset) begin
                     err_stop <= 1'b0;
                  end else if (!err_stop && err_any) begin
                     err_stop <= 1'b1;
                     // switch picks restart or plain stop
                     state <= err_restart_sw ? r1_wait_dxu : s5_wait_dxu;
                  end
               end
               r1_wait_dxu: begin
                  // stop the run and ask for restart reset at word start
                  if (tim.dxu) begin
                     restart_reset <= 1'b1;
                     err_stop_ed0u <= 1'b1;
                     state         <= r2_wait_busy;
                  end
               end
               r2_wait_busy: begin
                  if (restart_reset_busy) begin
                     restart_reset <= 1'b0;
                     state         <= r3_wait_end;
                  end
               end
               r3_wait_end: begin
                  // resume at the end of the band once reset is done
                  if (!restart_reset_busy && tim.wl && tim.d10) begin
                     err_sense_restart <= 1'b1;
                     err_stop          <= 1'b0;
                     state             <= r4_resume;
                  end
               end
               r4_resume: state <= idle;
               s5_wait_dxu: begin
                  // stop-only, drop the run latch at word start
                  if (tim.dxu) begin
                     err_stop_ed0u <= 1'b1;
                     state         <= s6_clear;
                  end
               end
               s6_clear: state <= idle;
               default:  state <= idle;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: restart_reset.sv
`timescale 1ns/10ps
`default_nettype none

module restart_reset (
   input  wire logic ap,
   input  wire logic rst,
   timing_if.usr     tim,
   input  wire logic restart_reset,
   output logic      restart_reset_busy
);

   import i650_pkg::*;

   logic                   req_q;
   logic [DIGIT_CNT_W-1:0] cnt;

   // all activity is paced by dp
   always_ff @(posedge ap) begin
      if (rst) begin
         req_q              <= 1'b0;
         restart_reset_busy <= 1'b0;
         cnt                <= '0;
      end else if (tim.dp) begin
         if (restart_reset_busy) begin
            // a request during busy is absorbed
            req_q <= 1'b0;
            // one full word of dp strobes, then drop busy
            if (cnt == DIGIT_CNT_W'(DIGITS_PER_WORD - 1)) begin
               restart_reset_busy <= 1'b0;
               cnt                <= '0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else if (req_q && tim.dxu) begin
            // latched request starts busy at word start
            restart_reset_busy <= 1'b1;
            req_q              <= 1'b0;
            cnt                <= '0;
         end else if (restart_reset) begin
            // hold the request until the next dxu
            req_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: validity_check.sv
`timescale 1ns/10ps
`default_nettype none

module validity_check (
   input  wire logic                          ap,
   input  wire logic                          rst,
   timing_if.usr                              tim,
   input  wire logic [i650_pkg::BQ_WIDTH-1:0] digit,
   input  wire logic                          check_en,
   output logic                               err_stop_sig
);

   import i650_pkg::*;

   logic [BQ_WIDTH-1:0] digit_q;
   logic                chk_q;
   logic                dp_q;
   logic [ONES_W-1:0]   bi_ones;
   logic [ONES_W-1:0]   qui_ones;

   // count of set bits in a group
   function automatic logic [ONES_W-1:0] ones_in(input logic [QUI_WIDTH-1:0] v);
      logic [ONES_W-1:0] n;
      n = '0;
      for (int i = 0; i < QUI_WIDTH; i++) begin
         n = n + ONES_W'(v[i]);
      end
      return n;
   endfunction

   // --------------------
   // stage 1, capture on dp
   // --------------------

   always_ff @(posedge ap) begin
      if (tim.dp) begin
         digit_q <= digit;
      end
   end

   always_ff @(posedge ap) begin
      if (rst) begin
         chk_q <= 1'b0;
         dp_q  <= 1'b0;
      end else begin
         // marks the cycle after a capture
         dp_q <= tim.dp;
         if (tim.dp) begin
            chk_q <= check_en;
         end
      end
   end

   // bi group is zero-extended to the quinary width
   assign bi_ones  = ones_in({{(QUI_WIDTH - BI_WIDTH){1'b0}}, digit_q[BQ_WIDTH-1 -: BI_WIDTH]});
   assign qui_ones = ones_in(digit_q[QUI_WIDTH-1:0]);

   // --------------------
   // stage 2, one-cycle error pulse
   // --------------------

   always_ff @(posedge ap) begin
      if (rst) begin
         err_stop_sig <= 1'b0;
      end else begin
         // exactly one bi and one quinary bit make a legal digit
         err_stop_sig <= dp_q && chk_q &&
                         ((bi_ones != ONES_W'(1)) || (qui_ones != ONES_W'(1)));
      end
   end

endmodule

`default_nettype wire

// File: timing_ring.sv
`timescale 1ns/10ps
`default_nettype none

module timing_ring (
   input  wire logic ap,
   input  wire logic rst,
   timing_if.src     tim
);

   import i650_pkg::*;

   logic [DP_CNT_W-1:0]    pre;
   logic [DIGIT_CNT_W-1:0] digit;
   logic [WORD_CNT_W-1:0]  word;
   logic                   dp;

   // --------------------
   // prescaler
   // --------------------

   // dp on the last count, so the first strobe lands DP_DIV cycles out of reset
   assign dp = (pre == DP_CNT_W'(DP_DIV - 1));

   always_ff @(posedge ap) begin
      if (rst) begin
         pre <= '0;
      end else begin
         // power-of-two divide, wraps by itself
         pre <= pre + 1'b1;
      end
   end

   // --------------------
   // digit and word ring
   // --------------------

   always_ff @(posedge ap) begin
      if (rst) begin
         digit <= '0;
         word  <= '0;
      end else if (dp) begin
         if (digit == DIGIT_CNT_W'(DIGITS_PER_WORD - 1)) begin
            digit <= '0;
            // word advances as the digit ring wraps
            if (word == WORD_CNT_W'(WORDS_PER_BAND - 1)) begin
               word <= '0;
            end else begin
               word <= word + 1'b1;
            end
         end else begin
            digit <= digit + 1'b1;
         end
      end
   end

   // levels span the whole digit or word, users qualify with dp
   assign tim.dp  = dp;
   assign tim.dxu = (digit == '0);
   assign tim.d10 = (digit == DIGIT_CNT_W'(DIGITS_PER_WORD - 1));
   assign tim.wl  = (word == WORD_CNT_W'(WORDS_PER_BAND - 1));

endmodule

`default_nettype wire

// File: timing_if.sv
`timescale 1ns/10ps
`default_nettype none

// timing strobes from the ring to the control blocks
interface timing_if;

   // one ap cycle per digit period
   logic dp;
   // level over digit 0
   logic dxu;
   // level over digit 11
   logic d10;
   // level over the last word of the band
   logic wl;

   // the timing ring
   modport src (
      output dp,
      output dxu,
      output d10,
      output wl
   );

   // every block that qualifies events with dp
   modport usr (
      input dp,
      input dxu,
      input d10,
      input wl
   );

endinterface

`default_nettype wire

// File: i650_pkg.sv
`default_nettype none

package i650_pkg;

   // --------------------
   // drum timing
   // --------------------

   // ap cycles per digit period, one dp strobe each
   localparam int DP_DIV          = 4;
   // digit positions 0 to 11, dxu marks 0 and d10 marks 11
   localparam int DIGITS_PER_WORD = 12;
   // words per band, wl marks the last one
   localparam int WORDS_PER_BAND  = 50;

   // counter widths for the timing ring and the busy counter
   localparam int DP_CNT_W    = $clog2(DP_DIV);
   localparam int DIGIT_CNT_W = $clog2(DIGITS_PER_WORD);
   localparam int WORD_CNT_W  = $clog2(WORDS_PER_BAND);

   // --------------------
   // bi-quinary digit
   // --------------------

   // 2 bi bits on top, 5 quinary bits below
   localparam int BQ_WIDTH  = 7;
   localparam int BI_WIDTH  = 2;
   localparam int QUI_WIDTH = BQ_WIDTH - BI_WIDTH;
   // enough bits to count every set bit of the quinary group
   localparam int ONES_W    = $clog2(QUI_WIDTH + 1);

   // error stop / error restart sequence
   typedef enum logic [2:0] {
      idle,
      r1_wait_dxu,
      r2_wait_busy,
      r3_wait_end,
      r4_resume,
      s5_wait_dxu,
      s6_clear
   } restart_state_e;

   // cause of the most recent stop
   typedef enum logic [1:0] {
      cause_none,
      cause_clock,
      cause_validity
   } err_cause_e;

endpackage

`default_nettype wire
